// ==== bench/arb_assert.sv ====
// grant and response handshake assertions, bound into the shared memory top level
`timescale 1ns/1ns
`default_nettype none

module arb_assert
	#(
		parameter int num_masters = 4
	)
	(
		input wire clk,
		input wire reset,
		input wire [num_masters-1:0] request,
		input wire [num_masters-1:0] grant_oh,
		input wire [num_masters-1:0] bvalid,
		input wire [num_masters-1:0] bready,
		input wire [num_masters-1:0] rvalid,
		input wire [num_masters-1:0] rready
	);

	// number of assertion failures so far
	int fail_count = 0;

	// the arbiter names exactly one winner whenever someone asks and only among those asking
	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant_oh) && ((grant_oh & ~request) == '0) &&
		((grant_oh != '0) == (request != '0)))
	else
	begin
		$error("grant_oh %b does not fit request %b", grant_oh, request);
		fail_count++;
	end

	// only one transaction is outstanding, so only one response can be visible
	a_one_response: assert property (@(posedge clk) disable iff (reset)
		$onehot0(bvalid | rvalid))
	else
	begin
		$error("more than one requestor sees a response: %b", bvalid | rvalid);
		fail_count++;
	end

	// a response that is not yet accepted stays up on the next cycle
	for (genvar i = 0; i < num_masters; i++)
	begin : g_hold
		a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
			bvalid[i] && !bready[i] |=> bvalid[i])
		else
		begin
			$error("bvalid of requestor %0d dropped before bready", i);
			fail_count++;
		end
		a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
			rvalid[i] && !rready[i] |=> rvalid[i])
		else
		begin
			$error("rvalid of requestor %0d dropped before rready", i);
			fail_count++;
		end
	end

endmodule

bind shared_mem_top arb_assert #(
	.num_masters(num_masters)
) u_arb_assert (
	.clk(clk),
	.reset(reset),
	.request(u_mux.arb_request),
	.grant_oh(u_mux.grant_oh),
	.bvalid(m_bvalid),
	.bready(m_bready),
	.rvalid(m_rvalid),
	.rready(m_rready)
);

`default_nettype wire

// ==== bench/mem_checker.sv ====
// watches the shared memory ports, models memory contents and round-robin order, counts mismatches
`timescale 1ns/1ns
`default_nettype none

module mem_checker
	import arb_pkg::*;
	#(
		parameter int num_masters = default_num_masters,
		parameter int addr_width = default_addr_width,
		parameter int data_width = default_data_width,
		parameter int mem_words = default_mem_words
	)
	(
		input wire clk,
		input wire reset,
		input wire [num_masters-1:0] m_awvalid,
		input wire [num_masters-1:0] m_awready,
		input wire [num_masters*addr_width-1:0] m_awaddr,
		input wire [num_masters-1:0] m_wvalid,
		input wire [num_masters-1:0] m_wready,
		input wire [num_masters*data_width-1:0] m_wdata,
		input wire [num_masters*data_width/8-1:0] m_wstrb,
		input wire [num_masters-1:0] m_bvalid,
		input wire [num_masters-1:0] m_bready,
		input wire [num_masters*2-1:0] m_bresp,
		input wire [num_masters-1:0] m_arvalid,
		input wire [num_masters-1:0] m_arready,
		input wire [num_masters*addr_width-1:0] m_araddr,
		input wire [num_masters-1:0] m_rvalid,
		input wire [num_masters-1:0] m_rready,
		input wire [num_masters*data_width-1:0] m_rdata,
		input wire [num_masters*2-1:0] m_rresp,
		input wire [num_masters*data_width-1:0] exp_rdata,
		output int error_count,
		output int resp_count
	);

	localparam int strb_width = data_width / 8;

	logic [data_width-1:0] shadow [mem_words];
	logic [1:0] exp_resp;
	logic [data_width-1:0] exp_data;
	logic in_flight;
	int rr_ptr;
	int winner;

	task automatic compare(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	// walk upward from the pointer with wrap and serve the first requestor found
	function automatic int rr_pick(input logic [num_masters-1:0] req, input int ptr);
		for (int k = 0; k < num_masters; k++)
		begin
			if (req[(ptr + k) % num_masters])
				return (ptr + k) % num_masters;
		end
		return -1;
	endfunction

	always @(posedge clk or posedge reset)
	begin
		logic [num_masters-1:0] req;
		logic [num_masters-1:0] grant_vec;
		int word;
		if (reset)
		begin
			for (int i = 0; i < mem_words; i++)
				shadow[i] = 'x;
			in_flight = 1'b0;
			rr_ptr = 0;
			winner = 0;
			error_count = 0;
			resp_count = 0;
		end
		else
		begin
			req = (m_awvalid & m_wvalid) | m_arvalid;
			grant_vec = '0;
			if (in_flight)
				grant_vec[winner] = 1'b1;
			// readies and responses may only show up on the requestor being served
			compare("m_bvalid|m_rvalid outside grant", '0, (m_bvalid | m_rvalid) & ~grant_vec);
			compare("m_awready|m_wready|m_arready outside grant", '0,
				(m_awready | m_wready | m_arready) & ~grant_vec);
			if (!in_flight)
			begin
				if (req != '0)
				begin
					winner = rr_pick(req, rr_ptr);
					in_flight = 1'b1;
				end
			end
			else
			begin
				if (|(m_awvalid & m_awready))
				begin
					compare("m_awready", grant_vec, m_awvalid & m_awready);
					compare("m_wready", grant_vec, m_wvalid & m_wready);
					word = m_awaddr[winner*addr_width +: addr_width] >> 2;
					exp_resp = (word < mem_words) ? resp_okay : resp_slverr;
					// only strobed bytes merge and a failed write leaves the shadow untouched
					for (int b = 0; b < strb_width; b++)
					begin
						if (word < mem_words && m_wstrb[winner*strb_width + b])
							shadow[word][b*8 +: 8] = m_wdata[winner*data_width + b*8 +: 8];
					end
				end
				if (|(m_arvalid & m_arready))
				begin
					compare("m_arready", grant_vec, m_arvalid & m_arready);
					word = m_araddr[winner*addr_width +: addr_width] >> 2;
					exp_resp = (word < mem_words) ? resp_okay : resp_slverr;
					exp_data = (word < mem_words) ? shadow[word] : '0;
				end
				if (|(m_bvalid & m_bready))
				begin
					compare("m_bvalid", grant_vec, m_bvalid & m_bready);
					compare("m_bresp", exp_resp, m_bresp[winner*2 +: 2]);
				end
				if (|(m_rvalid & m_rready))
				begin
					compare("m_rvalid", grant_vec, m_rvalid & m_rready);
					compare("m_rresp", exp_resp, m_rresp[winner*2 +: 2]);
					compare("m_rdata", exp_data, m_rdata[winner*data_width +: data_width]);
					compare("m_rdata (table)", exp_rdata[winner*data_width +: data_width],
						m_rdata[winner*data_width +: data_width]);
				end
				// priority moves one place past the requestor just served
				if (|((m_bvalid & m_bready) | (m_rvalid & m_rready)))
				begin
					rr_ptr = (winner + 1) % num_masters;
					in_flight = 1'b0;
					resp_count++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_top.sv ====
// testbench top for the shared memory, runs grouped AXI4-Lite operations from a table on four requestors
`timescale 1ns/1ns
`default_nettype none

module tb_top
	import arb_pkg::*;
	();

	localparam int nm = default_num_masters;
	localparam int addr_width = default_addr_width;
	localparam int data_width = default_data_width;
	localparam int strb_width = data_width / 8;
	localparam int max_rows = 32;

	logic clk;
	logic reset;
	wire [nm-1:0] m_awvalid;
	wire [nm-1:0] m_awready;
	wire [nm*addr_width-1:0] m_awaddr;
	wire [nm-1:0] m_wvalid;
	wire [nm-1:0] m_wready;
	wire [nm*data_width-1:0] m_wdata;
	wire [nm*strb_width-1:0] m_wstrb;
	wire [nm-1:0] m_bvalid;
	wire [nm-1:0] m_bready;
	wire [nm*2-1:0] m_bresp;
	wire [nm-1:0] m_arvalid;
	wire [nm-1:0] m_arready;
	wire [nm*addr_width-1:0] m_araddr;
	wire [nm-1:0] m_rvalid;
	wire [nm-1:0] m_rready;
	wire [nm*data_width-1:0] m_rdata;
	wire [nm*2-1:0] m_rresp;
	wire [nm*data_width-1:0] exp_rdata;
	int error_count;
	int resp_count;

	// one row per operation and rows sharing a group number start together
	int row_group [max_rows];
	int row_req [max_rows];
	logic row_write [max_rows];
	logic [addr_width-1:0] row_addr [max_rows];
	logic [data_width-1:0] row_data [max_rows];
	logic [strb_width-1:0] row_strb [max_rows];
	logic row_pause [max_rows];
	int pause_len [max_rows];
	int num_rows;
	int num_groups;
	int cur_group;
	int drv_done [nm];
	int limit_cycles;
	logic [31:0] lfsr;

	shared_mem_top u_dut (.*);

	mem_checker u_check (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// fibonacci LFSR with taps 32, 22, 2 and 1 whose new bit enters at bit 0
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic all_done(input int g);
		logic ok;
		ok = 1'b1;
		for (int r = 0; r < nm; r++)
		begin
			if (drv_done[r] != g)
				ok = 1'b0;
		end
		return ok;
	endfunction

	task automatic add_row(input int g, input int r, input logic wr,
		input logic [addr_width-1:0] a, input logic [data_width-1:0] d,
		input logic [strb_width-1:0] s, input logic p);
		row_group[num_rows] = g;
		row_req[num_rows] = r;
		row_write[num_rows] = wr;
		row_addr[num_rows] = a;
		row_data[num_rows] = d;
		row_strb[num_rows] = s;
		row_pause[num_rows] = p;
		num_rows++;
	endtask

	// each requestor has its own driver that runs its rows of each group in table order
	for (genvar r = 0; r < nm; r++)
	begin : g_drv
		logic awvalid;
		logic wvalid;
		logic bready;
		logic arvalid;
		logic rready;
		logic [addr_width-1:0] awaddr;
		logic [addr_width-1:0] araddr;
		logic [data_width-1:0] wdata;
		logic [data_width-1:0] exp;
		logic [strb_width-1:0] wstrb;

		assign m_awvalid[r] = awvalid;
		assign m_awaddr[r*addr_width +: addr_width] = awaddr;
		assign m_wvalid[r] = wvalid;
		assign m_wdata[r*data_width +: data_width] = wdata;
		assign m_wstrb[r*strb_width +: strb_width] = wstrb;
		assign m_bready[r] = bready;
		assign m_arvalid[r] = arvalid;
		assign m_araddr[r*addr_width +: addr_width] = araddr;
		assign m_rready[r] = rready;
		assign exp_rdata[r*data_width +: data_width] = exp;

		initial
		begin
			awvalid = 1'b0;
			wvalid = 1'b0;
			bready = 1'b0;
			arvalid = 1'b0;
			rready = 1'b0;
			awaddr = '0;
			araddr = '0;
			wdata = '0;
			wstrb = '0;
			exp = '0;
			drv_done[r] = -1;
			wait (num_groups > 0);
			for (int g = 0; g < num_groups; g++)
			begin
				wait (cur_group == g);
				for (int i = 0; i < num_rows; i++)
				begin
					if (row_group[i] == g && row_req[i] == r)
					begin
						// a pause row keeps the response waiting before ready goes high
						bready = !row_pause[i];
						rready = !row_pause[i];
						if (row_write[i])
						begin
							awaddr = row_addr[i];
							wdata = row_data[i];
							wstrb = row_strb[i];
							awvalid = 1'b1;
							wvalid = 1'b1;
							do @(negedge clk); while (!m_awready[r]);
						end
						else
						begin
							araddr = row_addr[i];
							exp = row_data[i];
							arvalid = 1'b1;
							do @(negedge clk); while (!m_arready[r]);
						end
						@(posedge clk);
						#1;
						awvalid = 1'b0;
						wvalid = 1'b0;
						arvalid = 1'b0;
						do @(negedge clk); while (!(m_bvalid[r] || m_rvalid[r]));
						if (row_pause[i])
						begin
							repeat (pause_len[i]) @(posedge clk);
							#1;
							bready = 1'b1;
							rready = 1'b1;
						end
						// the response is taken on this edge
						@(posedge clk);
						#1;
						bready = 1'b0;
						rready = 1'b0;
					end
				end
				drv_done[r] = g;
			end
		end
	end

	initial
	begin
		int errors;
		int pause_total;
		reset = 1'b1;
		num_rows = 0;
		num_groups = 0;
		cur_group = -1;
		limit_cycles = 0;
		// single word access, strobe merge, out-of-range answers
		add_row(0, 0, 1, 8'h00, 32'h1122_3344, 4'hf, 0);
		add_row(1, 0, 0, 8'h00, 32'h1122_3344, 4'h0, 0);
		add_row(1, 1, 1, 8'h04, 32'haabb_ccdd, 4'hf, 0);
		add_row(2, 1, 1, 8'h04, 32'h00ee_0055, 4'h5, 0);
		add_row(2, 2, 1, 8'h80, 32'hdead_beef, 4'hf, 0);
		add_row(3, 1, 0, 8'h04, 32'haaee_cc55, 4'h0, 0);
		add_row(3, 2, 0, 8'h80, 32'h0000_0000, 4'h0, 0);
		add_row(3, 3, 0, 8'h00, 32'h1122_3344, 4'h0, 0);
		// all four requestors write at once
		add_row(4, 0, 1, 8'h10, 32'hc0de_0000, 4'hf, 0);
		add_row(4, 1, 1, 8'h14, 32'hc0de_0001, 4'hf, 0);
		add_row(4, 2, 1, 8'h18, 32'hc0de_0002, 4'hf, 0);
		add_row(4, 3, 1, 8'h1c, 32'hc0de_0003, 4'hf, 0);
		// requestor 0 asks back to back while the others are pending
		add_row(5, 0, 1, 8'h20, 32'h0101_0101, 4'hf, 0);
		add_row(5, 0, 1, 8'h24, 32'h0202_0202, 4'hf, 0);
		add_row(5, 0, 0, 8'h10, 32'hc0de_0000, 4'h0, 0);
		add_row(5, 1, 0, 8'h14, 32'hc0de_0001, 4'h0, 0);
		add_row(5, 2, 0, 8'h18, 32'hc0de_0002, 4'h0, 0);
		add_row(5, 3, 0, 8'h1c, 32'hc0de_0003, 4'h0, 0);
		// random response back-pressure under contention
		add_row(6, 0, 0, 8'h20, 32'h0101_0101, 4'h0, 1);
		add_row(6, 1, 0, 8'h24, 32'h0202_0202, 4'h0, 1);
		add_row(6, 2, 1, 8'h28, 32'h3333_4444, 4'hf, 1);
		add_row(6, 3, 1, 8'h2c, 32'h5555_6666, 4'hf, 1);
		add_row(7, 0, 0, 8'h2c, 32'h5555_6666, 4'h0, 1);
		add_row(7, 1, 0, 8'h28, 32'h3333_4444, 4'h0, 1);
		add_row(7, 2, 1, 8'h7c, 32'h9999_aaaa, 4'hf, 1);
		add_row(7, 3, 0, 8'hfc, 32'h0000_0000, 4'h0, 1);
		// each stall lasts 1 to 8 cycles and takes three LFSR bits
		pause_total = 0;
		lfsr = 32'h27a4;
		for (int i = 0; i < num_rows; i++)
		begin
			pause_len[i] = 0;
			if (row_pause[i])
			begin
				for (int b = 0; b < 3; b++)
				begin
					lfsr = lfsr_next(lfsr);
					pause_len[i] = pause_len[i] * 2 + lfsr[0];
				end
				pause_len[i] = pause_len[i] + 1;
				pause_total = pause_total + pause_len[i];
			end
		end
		limit_cycles = num_rows * 40 + 3 + pause_total;
		num_groups = 8;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int g = 0; g < num_groups; g++)
		begin
			cur_group = g;
			do @(posedge clk); while (!all_done(g));
			#1;
		end
		repeat (2) @(posedge clk);
		errors = error_count + u_dut.u_arb_assert.fail_count;
		if (resp_count != num_rows)
		begin
			$display("only %0d of %0d table operations got a response", resp_count, num_rows);
			errors++;
		end
		$display("responses %0d, errors %0d", resp_count, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// the watchdog starts once the stall lengths are drawn and the limit is known
	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", limit_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/arb_pkg.sv ====
// shared response codes and width defaults, imported by the memory subsystem RTL and its bench
`default_nettype none

package arb_pkg;

	// AXI4-Lite response code as carried on bresp and rresp
	// exokay and decerr are never produced by this subsystem, so only two values exist
	typedef enum logic [1:0]
	{
		resp_okay = 2'b00,
		resp_slverr = 2'b10
	} resp_t;

	// number of AXI4-Lite requestors sharing the memory
	localparam int default_num_masters = 4;

	// byte address width on every AW and AR channel
	localparam int default_addr_width = 8;

	// data width of the W and R channels
	// the strobe width follows from it as one bit per byte
	localparam int default_data_width = 32;

	// memory depth in words
	// with 32-bit words this covers byte addresses 0 to 127, anything above answers slverr
	localparam int default_mem_words = 32;

endpackage

`default_nettype wire

// ==== logic/arbiter.sv ====
// round-robin arbiter giving a same-cycle one-hot grant from a request vector, updated by update_lru
`timescale 1ns/1ns
`default_nettype none

module arbiter
	#(
		parameter int num_entries = 4,
		parameter int switch_every_cycle = 1
	)
	(
		input wire clk,
		input wire reset,
		input wire [num_entries-1:0] request,
		input wire update_lru,
		output logic [num_entries-1:0] grant_oh
	);

	// one-hot pointer to the unit that currently has top priority
	logic [num_entries-1:0] priority_oh;
	logic [num_entries-1:0] priority_oh_nxt;
	logic [2*num_entries-1:0] request_x2;
	logic [2*num_entries-1:0] grant_x2;

	// subtracting the priority bit borrows up to the first set request at or above it
	// the doubled copy lets that borrow wrap past the top unit back to unit 0
	assign request_x2 = {request, request};
	assign grant_x2 = request_x2 & ~(request_x2 - {{num_entries{1'b0}}, priority_oh});

	// the winner shows up in either half, depending on whether the search wrapped
	assign grant_oh = grant_x2[2*num_entries-1:num_entries] | grant_x2[num_entries-1:0];

	generate
		if (switch_every_cycle != 0)
		begin : g_rotate
			// next priority is the unit just above the winner, so the winner goes last
			assign priority_oh_nxt = {grant_oh[num_entries-2:0], grant_oh[num_entries-1]};
		end
		else
		begin : g_hold
			// the winner keeps priority and is served again while it keeps asking
			assign priority_oh_nxt = grant_oh;
		end
	endgenerate

	// without any request the grant is zero, so the pointer must not move then
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			priority_oh <= {{(num_entries-1){1'b0}}, 1'b1};
		else if (update_lru && (request != '0))
			priority_oh <= priority_oh_nxt;
	end

endmodule

`default_nettype wire

// ==== logic/axil_arb_mux.sv ====
// arbitrates the AXI4-Lite requestors, holds one grant per transaction and routes it to the memory
`timescale 1ns/1ns
`default_nettype none

module axil_arb_mux
	import arb_pkg::*;
	#(
		parameter int num_masters = default_num_masters,
		parameter int addr_width = default_addr_width,
		parameter int data_width = default_data_width,
		parameter int switch_every_cycle = 1
	)
	(
		input wire clk,
		input wire reset,
		input wire [num_masters-1:0] m_awvalid,
		output logic [num_masters-1:0] m_awready,
		input wire [num_masters*addr_width-1:0] m_awaddr,
		input wire [num_masters-1:0] m_wvalid,
		output logic [num_masters-1:0] m_wready,
		input wire [num_masters*data_width-1:0] m_wdata,
		input wire [num_masters*data_width/8-1:0] m_wstrb,
		output logic [num_masters-1:0] m_bvalid,
		input wire [num_masters-1:0] m_bready,
		output logic [num_masters*2-1:0] m_bresp,
		input wire [num_masters-1:0] m_arvalid,
		output logic [num_masters-1:0] m_arready,
		input wire [num_masters*addr_width-1:0] m_araddr,
		output logic [num_masters-1:0] m_rvalid,
		input wire [num_masters-1:0] m_rready,
		output logic [num_masters*data_width-1:0] m_rdata,
		output logic [num_masters*2-1:0] m_rresp,
		axil_if.master mem
	);

	localparam int strb_width = data_width / 8;

	typedef enum logic [1:0] {st_idle, st_write, st_read, st_resp} state_t;

	state_t state;
	logic [num_masters-1:0] wr_request;
	logic [num_masters-1:0] live_request;
	logic [num_masters-1:0] arb_request;
	logic [num_masters-1:0] grant_oh;
	logic [num_masters-1:0] grant_q;
	logic grant_is_write;
	logic is_write_q;
	logic resp_done;

	// payload of the granted requestor, all zero while grant_q is empty
	logic sel_awvalid;
	logic sel_wvalid;
	logic sel_bready;
	logic sel_arvalid;
	logic sel_rready;
	logic [addr_width-1:0] sel_awaddr;
	logic [addr_width-1:0] sel_araddr;
	logic [data_width-1:0] sel_wdata;
	logic [strb_width-1:0] sel_wstrb;

	// a write only counts once AW and W are both presented
	assign wr_request = m_awvalid & m_wvalid;
	assign live_request = wr_request | m_arvalid;

	// while a transaction runs the arbiter sees only the held winner
	// which makes update_lru rotate the pointer past that winner and nobody else
	assign arb_request = (state == st_idle) ? live_request : grant_q;

	// a requestor with both a write and a read pending gets the write first
	assign grant_is_write = |(grant_oh & wr_request);

	assign resp_done = (state == st_resp) &&
		(is_write_q ? (mem.bvalid && mem.bready) : (mem.rvalid && mem.rready));

	arbiter #(
		.num_entries(num_masters),
		.switch_every_cycle(switch_every_cycle)
	) u_arbiter (
		.clk(clk),
		.reset(reset),
		.request(arb_request),
		.update_lru(resp_done),
		.grant_oh(grant_oh)
	);

	// transaction FSM, grant and direction stay fixed from idle until the response is taken
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= st_idle;
			grant_q <= '0;
			is_write_q <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
					if (|live_request)
					begin
						grant_q <= grant_oh;
						is_write_q <= grant_is_write;
						state <= grant_is_write ? st_write : st_read;
					end
				st_write:
					if (mem.awvalid && mem.awready)
						state <= st_resp;
				st_read:
					if (mem.arvalid && mem.arready)
						state <= st_resp;
				st_resp:
					if (resp_done)
					begin
						state <= st_idle;
						grant_q <= '0;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	// and-or select, grant_q is one-hot or zero
	always_comb
	begin
		sel_awvalid = |(grant_q & m_awvalid);
		sel_wvalid = |(grant_q & m_wvalid);
		sel_bready = |(grant_q & m_bready);
		sel_arvalid = |(grant_q & m_arvalid);
		sel_rready = |(grant_q & m_rready);
		sel_awaddr = '0;
		sel_araddr = '0;
		sel_wdata = '0;
		sel_wstrb = '0;
		for (int i = 0; i < num_masters; i++)
		begin
			if (grant_q[i])
			begin
				sel_awaddr = sel_awaddr | m_awaddr[i*addr_width +: addr_width];
				sel_araddr = sel_araddr | m_araddr[i*addr_width +: addr_width];
				sel_wdata = sel_wdata | m_wdata[i*data_width +: data_width];
				sel_wstrb = sel_wstrb | m_wstrb[i*strb_width +: strb_width];
			end
		end
	end

	// each channel is only opened to the memory in its own phase
	assign mem.awvalid = (state == st_write) && sel_awvalid;
	assign mem.wvalid = (state == st_write) && sel_wvalid;
	assign mem.awaddr = sel_awaddr;
	assign mem.wdata = sel_wdata;
	assign mem.wstrb = sel_wstrb;
	assign mem.arvalid = (state == st_read) && sel_arvalid;
	assign mem.araddr = sel_araddr;
	assign mem.bready = (state == st_resp) && is_write_q && sel_bready;
	assign mem.rready = (state == st_resp) && !is_write_q && sel_rready;

	// steer handshakes and responses back to the granted requestor only
	for (genvar i = 0; i < num_masters; i++)
	begin : g_demux
		assign m_awready[i] = grant_q[i] && (state == st_write) && mem.awready;
		assign m_wready[i] = grant_q[i] && (state == st_write) && mem.wready;
		assign m_arready[i] = grant_q[i] && (state == st_read) && mem.arready;
		assign m_bvalid[i] = grant_q[i] && (state == st_resp) && is_write_q && mem.bvalid;
		assign m_rvalid[i] = grant_q[i] && (state == st_resp) && !is_write_q && mem.rvalid;
		assign m_bresp[i*2 +: 2] = grant_q[i] ? mem.bresp : resp_okay;
		assign m_rresp[i*2 +: 2] = grant_q[i] ? mem.rresp : resp_okay;
		assign m_rdata[i*data_width +: data_width] = grant_q[i] ? mem.rdata : '0;
	end

endmodule

`default_nettype wire

// ==== logic/axil_if.sv ====
// AXI4-Lite channel bundle linking the request multiplexer (master side) to the memory (slave side)
`timescale 1ns/1ns
`default_nettype none

interface axil_if
	import arb_pkg::*;
	#(
		parameter int addr_width = default_addr_width,
		parameter int data_width = default_data_width
	)
	();

	// write address channel
	logic awvalid;
	logic awready;
	logic [addr_width-1:0] awaddr;

	// write data channel, one strobe bit per byte lane
	logic wvalid;
	logic wready;
	logic [data_width-1:0] wdata;
	logic [data_width/8-1:0] wstrb;

	// write response channel
	logic bvalid;
	logic bready;
	resp_t bresp;

	// read address channel
	logic arvalid;
	logic arready;
	logic [addr_width-1:0] araddr;

	// read data channel
	logic rvalid;
	logic rready;
	logic [data_width-1:0] rdata;
	resp_t rresp;

	// the multiplexer drives requests and accepts responses
	modport master (
		output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
		input awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
	);

	// the memory accepts requests and drives responses
	modport slave (
		input awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
		output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
	);

endinterface

`default_nettype wire

// ==== logic/axil_sram.sv ====
// word-addressed AXI4-Lite memory slave with byte strobes, answering slverr beyond its depth
`timescale 1ns/1ns
`default_nettype none

module axil_sram
	import arb_pkg::*;
	#(
		parameter int addr_width = default_addr_width,
		parameter int data_width = default_data_width,
		parameter int mem_words = default_mem_words
	)
	(
		input wire clk,
		input wire reset,
		axil_if.slave s
	);

	localparam int strb_width = data_width / 8;
	localparam int offset_bits = $clog2(strb_width);
	localparam int index_bits = $clog2(mem_words);

	logic [data_width-1:0] mem_array [mem_words];
	logic busy;
	logic wr_accept;
	logic rd_accept;
	logic [addr_width-1:0] wr_word;
	logic [addr_width-1:0] rd_word;
	logic wr_in_range;
	logic rd_in_range;

	// only one response can be pending, new requests wait until it has been taken
	assign busy = s.bvalid || s.rvalid;

	// AW and W are taken together in a single cycle, and a write wins over a read
	assign wr_accept = s.awvalid && s.wvalid && !busy;
	assign rd_accept = s.arvalid && !busy && !wr_accept;
	assign s.awready = wr_accept;
	assign s.wready = wr_accept;
	assign s.arready = rd_accept;

	// byte address to word index, the full word number decides the range check
	assign wr_word = s.awaddr >> offset_bits;
	assign rd_word = s.araddr >> offset_bits;
	assign wr_in_range = wr_word < addr_width'(mem_words);
	assign rd_in_range = rd_word < addr_width'(mem_words);

	// merge only the strobed bytes into the stored word
	always_ff @(posedge clk)
	begin
		if (wr_accept && wr_in_range)
		begin
			for (int b = 0; b < strb_width; b++)
			begin
				if (s.wstrb[b])
					mem_array[wr_word[index_bits-1:0]][b*8 +: 8] <= s.wdata[b*8 +: 8];
			end
		end
	end

	// response valids rise the edge after the request and hold until taken
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s.bvalid <= 1'b0;
			s.rvalid <= 1'b0;
		end
		else
		begin
			if (wr_accept)
				s.bvalid <= 1'b1;
			else if (s.bvalid && s.bready)
				s.bvalid <= 1'b0;

			if (rd_accept)
				s.rvalid <= 1'b1;
			else if (s.rvalid && s.rready)
				s.rvalid <= 1'b0;
		end
	end

	// response payload captured with the request, steady while the valid waits
	always_ff @(posedge clk)
	begin
		if (wr_accept)
			s.bresp <= wr_in_range ? resp_okay : resp_slverr;
		if (rd_accept)
		begin
			s.rresp <= rd_in_range ? resp_okay : resp_slverr;
			s.rdata <= rd_in_range ? mem_array[rd_word[index_bits-1:0]] : '0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/shared_mem_top.sv ====
// top level of the shared memory, with per-requestor AXI4-Lite channels packed into flat vectors
`timescale 1ns/1ns
`default_nettype none

module shared_mem_top
	import arb_pkg::*;
	#(
		parameter int num_masters = default_num_masters,
		parameter int addr_width = default_addr_width,
		parameter int data_width = default_data_width,
		parameter int mem_words = default_mem_words,
		parameter int switch_every_cycle = 1
	)
	(
		input wire clk,
		input wire reset,
		input wire [num_masters-1:0] m_awvalid,
		output wire [num_masters-1:0] m_awready,
		input wire [num_masters*addr_width-1:0] m_awaddr,
		input wire [num_masters-1:0] m_wvalid,
		output wire [num_masters-1:0] m_wready,
		input wire [num_masters*data_width-1:0] m_wdata,
		input wire [num_masters*data_width/8-1:0] m_wstrb,
		output wire [num_masters-1:0] m_bvalid,
		input wire [num_masters-1:0] m_bready,
		output wire [num_masters*2-1:0] m_bresp,
		input wire [num_masters-1:0] m_arvalid,
		output wire [num_masters-1:0] m_arready,
		input wire [num_masters*addr_width-1:0] m_araddr,
		output wire [num_masters-1:0] m_rvalid,
		input wire [num_masters-1:0] m_rready,
		output wire [num_masters*data_width-1:0] m_rdata,
		output wire [num_masters*2-1:0] m_rresp
	);

	// single link between the arbitrating multiplexer and the memory
	axil_if #(
		.addr_width(addr_width),
		.data_width(data_width)
	) mem_bus ();

	// requestor i sits on slice i of every vector
	axil_arb_mux #(
		.num_masters(num_masters),
		.addr_width(addr_width),
		.data_width(data_width),
		.switch_every_cycle(switch_every_cycle)
	) u_mux (
		.clk(clk),
		.reset(reset),
		.m_awvalid(m_awvalid),
		.m_awready(m_awready),
		.m_awaddr(m_awaddr),
		.m_wvalid(m_wvalid),
		.m_wready(m_wready),
		.m_wdata(m_wdata),
		.m_wstrb(m_wstrb),
		.m_bvalid(m_bvalid),
		.m_bready(m_bready),
		.m_bresp(m_bresp),
		.m_arvalid(m_arvalid),
		.m_arready(m_arready),
		.m_araddr(m_araddr),
		.m_rvalid(m_rvalid),
		.m_rready(m_rready),
		.m_rdata(m_rdata),
		.m_rresp(m_rresp),
		.mem(mem_bus.master)
	);

	axil_sram #(
		.addr_width(addr_width),
		.data_width(data_width),
		.mem_words(mem_words)
	) u_sram (
		.clk(clk),
		.reset(reset),
		.s(mem_bus.slave)
	);

endmodule

`default_nettype wire

// ==== tb.f ====
logic/arb_pkg.sv
logic/axil_if.sv
logic/arbiter.sv
logic/axil_arb_mux.sv
logic/axil_sram.sv
logic/shared_mem_top.sv
bench/mem_checker.sv
bench/arb_assert.sv
bench/tb_top.sv
